//--- lm_pkg.sv
// line doubler shared widths, sync bit positions, output timing and register map
`default_nettype none

package lm_pkg;

  ////////////////////////////////////////////////////////////
  // video word layout {nVSYNC, 0, nHSYNC, nCSYNC, R, G, B}
  ////////////////////////////////////////////////////////////

  parameter int COLOR_W_I = 7;   // bits per channel in
  parameter int COLOR_W_O = 8;   // bits per channel out

  parameter int VDATA_W_I = 4 + 3*COLOR_W_I;
  parameter int VDATA_W_O = 4 + 3*COLOR_W_O;

  // positions inside the sync nibble, bit 2 unused
  parameter int SYNC_VS = 3;
  parameter int SYNC_HS = 1;
  parameter int SYNC_CS = 0;

  ////////////////////////////////////////////////////////////
  // buffer and output timing
  ////////////////////////////////////////////////////////////

  parameter int BUF_PAGES   = 2;  // ping-pong
  parameter int LINE_CNT_W  = 12; // input line period counter
  parameter int HS_WIDTH_2X = 16; // output nHSYNC low cycles
  parameter int VS_LINES    = 6;  // output lines with nVSYNC low

  // apb register byte addresses
  parameter logic [7:0] ADDR_CTRL   = 8'h00;
  parameter logic [7:0] ADDR_SL_STR = 8'h04;

endpackage

`default_nettype wire

//--- lm_apb_regs.sv
// zero wait state apb slave with the line doubler control and scanline strength registers
`default_nettype none

module lm_apb_regs (
  input  logic        VCLK_o,
  input  logic        nVRST_o,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [7:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic        mult_en_o,
  output logic        sl_en_o,
  output logic        sl_id_o,
  output logic [7:0]  sl_str_o
);

  logic       access;
  logic       addr_ok;
  logic [2:0] ctrl_q;    // {sl_id, sl_en, mult_en}
  logic [7:0] sl_str_q;

  assign access  = psel_i & penable_i;
  assign addr_ok = (paddr_i == lm_pkg::ADDR_CTRL) || (paddr_i == lm_pkg::ADDR_SL_STR);

  assign pready_o  = 1'b1;           // never stretch
  assign pslverr_o = access & ~addr_ok;

  always_comb begin
    prdata_o = 32'h0;
    if (paddr_i == lm_pkg::ADDR_CTRL)
      prdata_o = {29'h0, ctrl_q};
    else if (paddr_i == lm_pkg::ADDR_SL_STR)
      prdata_o = {24'h0, sl_str_q};
  end

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      ctrl_q   <= 3'b000;
      sl_str_q <= 8'h00;
    end else if (access && pwrite_i) begin
      if (paddr_i == lm_pkg::ADDR_CTRL)
        ctrl_q <= pwdata_i[2:0];
      if (paddr_i == lm_pkg::ADDR_SL_STR)
        sl_str_q <= pwdata_i[7:0];
    end
  end

  assign mult_en_o = ctrl_q[0];
  assign sl_en_o   = ctrl_q[1];
  assign sl_id_o   = ctrl_q[2];
  assign sl_str_o  = sl_str_q;

  // access phase must always follow a selected setup phase
  a_penable_needs_psel: assert property (
    @(posedge VCLK_o) disable iff (!nVRST_o) penable_i |-> psel_i
  ) else $error("apb: penable without psel");

endmodule

`default_nettype wire

//--- lm_line_writer.sv
// input side of the line doubler, sync edges, line period and buffer write addressing
`default_nettype none

module lm_line_writer #(
  parameter int BUF_DEPTH = 64,
  parameter int H_START   = 8
) (
  input  logic                              VCLK_o,
  input  logic                              nVRST_o,
  input  logic                              vdata_valid_i,
  input  logic [lm_pkg::VDATA_W_I-1:0]      vdata_i,
  output logic                              wr_en_o,
  output logic                              wr_page_o,
  output logic [$clog2(BUF_DEPTH)-1:0]      wr_addr_o,
  output logic [3*lm_pkg::COLOR_W_I-1:0]    wr_data_o,
  output logic                              line_done_o,
  output logic                              done_page_o,
  output logic [lm_pkg::LINE_CNT_W-1:0]     line_period_o,
  output logic                              frame_start_o
);

  localparam int ADDR_W = $clog2(BUF_DEPTH);
  localparam int CNT_W  = lm_pkg::LINE_CNT_W;
  localparam int SY_LSB = lm_pkg::VDATA_W_I - 4;

  logic [3:0]       sync_cur;
  logic [3:0]       sync_prev;  // syncs of the last valid pixel
  logic             hs_fall;
  logic             vs_fall;
  logic [CNT_W-1:0] cyc_cnt;    // clocks since last hsync fall
  logic [CNT_W-1:0] wr_hcnt;    // valid pixels since last hsync fall
  logic [CNT_W-1:0] pix_idx;
  logic             in_window;

  assign sync_cur = vdata_i[SY_LSB +: 4];
  assign hs_fall  = vdata_valid_i & sync_prev[lm_pkg::SYNC_HS] & ~sync_cur[lm_pkg::SYNC_HS];
  assign vs_fall  = vdata_valid_i & sync_prev[lm_pkg::SYNC_VS] & ~sync_cur[lm_pkg::SYNC_VS];

  // the falling pixel itself is pixel 0
  assign pix_idx   = hs_fall ? '0 : wr_hcnt;
  assign in_window = vdata_valid_i && (pix_idx >= CNT_W'(H_START)) &&
                     (pix_idx < CNT_W'(H_START + BUF_DEPTH));

  ////////////////////////////////////////////////////////////
  // counters and page control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      sync_prev     <= 4'h0;
      cyc_cnt       <= '0;
      wr_hcnt       <= '0;
      wr_page_o     <= 1'b0;
      wr_en_o       <= 1'b0;
      line_done_o   <= 1'b0;
      frame_start_o <= 1'b0;
    end else begin
      line_done_o   <= hs_fall;
      frame_start_o <= vs_fall;
      wr_en_o       <= in_window;
      if (vdata_valid_i)
        sync_prev <= sync_cur;
      if (hs_fall) begin
        cyc_cnt   <= CNT_W'(1);
        wr_hcnt   <= CNT_W'(1);
        wr_page_o <= ~wr_page_o;  // swap pages
      end else begin
        if (cyc_cnt != '1)
          cyc_cnt <= cyc_cnt + 1'b1;  // saturate on missing sync
        if (vdata_valid_i && wr_hcnt != '1)
          wr_hcnt <= wr_hcnt + 1'b1;
      end
    end
  end

  // payload, qualified by wr_en_o and line_done_o
  always_ff @(posedge VCLK_o) begin
    if (hs_fall) begin
      done_page_o   <= wr_page_o;
      line_period_o <= cyc_cnt;
    end
    wr_addr_o <= ADDR_W'(pix_idx - CNT_W'(H_START));
    wr_data_o <= vdata_i[3*lm_pkg::COLOR_W_I-1:0];
  end

  a_wr_addr_range: assert property (
    @(posedge VCLK_o) disable iff (!nVRST_o) wr_en_o |-> (wr_addr_o < BUF_DEPTH)
  ) else $error("writer: address beyond line buffer");

endmodule

`default_nettype wire

//--- lm_line_buffer.sv
// two page dual port line memory with registered read
`default_nettype none

module lm_line_buffer #(
  parameter int BUF_DEPTH = 64
) (
  input  logic                           VCLK_o,
  input  logic                           wr_en_i,
  input  logic                           wr_page_i,
  input  logic [$clog2(BUF_DEPTH)-1:0]   wr_addr_i,
  input  logic [3*lm_pkg::COLOR_W_I-1:0] wr_data_i,
  input  logic                           rd_en_i,
  input  logic                           rd_page_i,
  input  logic [$clog2(BUF_DEPTH)-1:0]   rd_addr_i,
  output logic [3*lm_pkg::COLOR_W_I-1:0] rd_data_o
);

  logic [3*lm_pkg::COLOR_W_I-1:0] mem [lm_pkg::BUF_PAGES][BUF_DEPTH];

  always_ff @(posedge VCLK_o) begin
    if (wr_en_i)
      mem[wr_page_i][wr_addr_i] <= wr_data_i;
    if (rd_en_i)
      rd_data_o <= mem[rd_page_i][rd_addr_i];  // one cycle latency
  end

  // writer and reader must stay on opposite pages
  a_page_conflict: assert property (
    @(posedge VCLK_o) !(wr_en_i && rd_en_i && (wr_page_i == rd_page_i))
  ) else $error("buffer: read and write on the same page");

endmodule

`default_nettype wire

//--- lm_line_reader.sv
// read sequencer replaying every stored line twice with new output syncs
`default_nettype none

module lm_line_reader #(
  parameter int BUF_DEPTH = 64,
  parameter int H_START   = 8
) (
  input  logic                          VCLK_o,
  input  logic                          nVRST_o,
  input  logic                          mult_en_i,
  input  logic                          sl_en_i,
  input  logic                          sl_id_i,
  input  logic                          line_done_i,
  input  logic                          done_page_i,
  input  logic [lm_pkg::LINE_CNT_W-1:0] line_period_i,
  input  logic                          frame_start_i,
  output logic                          rd_en_o,
  output logic                          rd_page_o,
  output logic [$clog2(BUF_DEPTH)-1:0]  rd_addr_o,
  output logic                          pix_valid_o,
  output logic                          draw_sl_o,
  output logic                          line_active_o,
  output logic [3:0]                    sync_o
);

  localparam int ADDR_W  = $clog2(BUF_DEPTH);
  localparam int HC_W    = lm_pkg::LINE_CNT_W - 1;  // half period fits here
  localparam int VC_W    = $clog2(lm_pkg::VS_LINES + 1);
  localparam int X_START = 2*H_START;
  localparam int X_STOP  = 2*(H_START + BUF_DEPTH);

  logic            active_q;     // idle / replaying
  logic            frame_pend;
  logic [HC_W-1:0] out_len;
  logic [HC_W-1:0] hcnt;
  logic [HC_W-1:0] x_rel;
  logic [1:0]      rep_q;        // repetition index
  logic [VC_W-1:0] vcnt;         // output line, saturates at VS_LINES
  logic [VC_W-1:0] vcnt_inc;
  logic            hs_n;
  logic            vs_act;

  assign vcnt_inc = (vcnt == VC_W'(lm_pkg::VS_LINES)) ? vcnt : vcnt + 1'b1;

  ////////////////////////////////////////////////////////////
  // replay state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      active_q   <= 1'b0;
      frame_pend <= 1'b0;
      out_len    <= '0;
      hcnt       <= '0;
      rep_q      <= 2'd0;
      vcnt       <= VC_W'(lm_pkg::VS_LINES);
      rd_page_o  <= 1'b0;
    end else if (!mult_en_i) begin
      active_q   <= 1'b0;
      frame_pend <= 1'b0;
      hcnt       <= '0;
      rep_q      <= 2'd0;
      vcnt       <= VC_W'(lm_pkg::VS_LINES);
    end else if (line_done_i) begin
      active_q   <= 1'b1;
      rd_page_o  <= done_page_i;
      out_len    <= line_period_i[lm_pkg::LINE_CNT_W-1:1];
      hcnt       <= '0;
      rep_q      <= 2'd0;
      frame_pend <= 1'b0;
      vcnt       <= (frame_pend || frame_start_i) ? '0 : vcnt_inc;
    end else begin
      if (frame_start_i)
        frame_pend <= 1'b1;  // applied at next line_done
      if (active_q) begin
        if (hcnt == out_len - 1'b1) begin
          hcnt  <= '0;
          rep_q <= (rep_q == 2'd1) ? 2'd0 : rep_q + 1'b1;
          vcnt  <= vcnt_inc;
        end else begin
          hcnt <= hcnt + 1'b1;
        end
      end
    end
  end

  // each stored pixel is read on two output pixels
  assign x_rel       = hcnt - HC_W'(X_START);
  assign pix_valid_o = active_q && (hcnt >= HC_W'(X_START)) && (hcnt < HC_W'(X_STOP));
  assign rd_en_o     = pix_valid_o;
  assign rd_addr_o   = ADDR_W'(x_rel >> 1);

  assign draw_sl_o     = active_q && sl_en_i && (rep_q == {1'b0, sl_id_i});
  assign line_active_o = active_q;

  assign hs_n   = !active_q || (hcnt >= HC_W'(lm_pkg::HS_WIDTH_2X));
  assign vs_act = active_q && (vcnt < VC_W'(lm_pkg::VS_LINES));

  always_comb begin
    sync_o                  = 4'b0000;
    sync_o[lm_pkg::SYNC_VS] = ~vs_act;
    sync_o[lm_pkg::SYNC_HS] = hs_n;
    sync_o[lm_pkg::SYNC_CS] = hs_n ^ vs_act;  // inverted during vsync
  end

  a_rep_range: assert property (
    @(posedge VCLK_o) disable iff (!nVRST_o) rep_q <= 2'd1
  ) else $error("reader: repetition index out of range");

endmodule

`default_nettype wire

//--- lm_scanline_out.sv
// output pipeline with scanline multiply, colour widening and bypass select
`default_nettype none

module lm_scanline_out (
  input  logic                           VCLK_o,
  input  logic                           nVRST_o,
  input  logic                           mult_en_i,
  input  logic [7:0]                     sl_str_i,
  input  logic                           vdata_valid_i,
  input  logic [lm_pkg::VDATA_W_I-1:0]   vdata_i,
  input  logic [3*lm_pkg::COLOR_W_I-1:0] rd_data_i,
  input  logic                           pix_valid_i,
  input  logic                           draw_sl_i,
  input  logic                           line_active_i,
  input  logic [3:0]                     sync_i,
  output logic                           vdata_valid_o,
  output logic [lm_pkg::VDATA_W_O-1:0]   vdata_o
);

  localparam int WI = lm_pkg::COLOR_W_I;
  localparam int WO = lm_pkg::COLOR_W_O;

  // msb repeated as new lsb
  function automatic logic [3*WO-1:0] widen(input logic [3*WI-1:0] c);
    logic [3*WO-1:0] r;
    for (int ch = 0; ch < 3; ch++)
      r[ch*WO +: WO] = {c[ch*WI +: WI], c[ch*WI + WI-1]};
    return r;
  endfunction

  // c * (255 - sl_str) >> 7 per channel
  function automatic logic [3*WO-1:0] darken(input logic [3*WI-1:0] c, input logic [7:0] k);
    logic [3*WO-1:0] r;
    logic [WI+7:0]   p;
    for (int ch = 0; ch < 3; ch++) begin
      p = c[ch*WI +: WI] * k;
      r[ch*WO +: WO] = p[WI+7:7];
    end
    return r;
  endfunction

  logic            pix_d1, sl_d1, act_d1;  // aligned with rd_data_i
  logic [3:0]      sync_d1;
  logic            pix_d2, sl_d2, act_d2;
  logic [3:0]      sync_d2;
  logic [3*WO-1:0] col_n_q;
  logic [3*WO-1:0] col_sl_q;
  logic [3*WO-1:0] col_sel;

  always_ff @(posedge VCLK_o or negedge nVRST_o) begin
    if (!nVRST_o) begin
      {pix_d1, sl_d1, act_d1, sync_d1} <= '0;
      {pix_d2, sl_d2, act_d2, sync_d2} <= '0;
      vdata_valid_o <= 1'b0;
      vdata_o       <= '0;
    end else begin
      {pix_d1, sl_d1, act_d1, sync_d1} <= {pix_valid_i, draw_sl_i, line_active_i, sync_i};
      {pix_d2, sl_d2, act_d2, sync_d2} <= {pix_d1, sl_d1, act_d1, sync_d1};
      if (!mult_en_i) begin  // straight through
        vdata_valid_o <= vdata_valid_i;
        vdata_o       <= {vdata_i[lm_pkg::VDATA_W_I-1 -: 4], widen(vdata_i[3*WI-1:0])};
      end else begin
        vdata_valid_o <= act_d2;
        vdata_o       <= {sync_d2, col_sel};
      end
    end
  end

  always_ff @(posedge VCLK_o) begin
    col_n_q  <= widen(rd_data_i);
    col_sl_q <= darken(rd_data_i, 8'hFF - sl_str_i);
  end

  assign col_sel = !pix_d2 ? '0 : (sl_d2 ? col_sl_q : col_n_q);

endmodule

`default_nettype wire

//--- linemult_top.sv
// line doubler top level with apb configuration
`default_nettype none

module linemult_top #(
  parameter int BUF_DEPTH = 64,
  parameter int H_START   = 8
) (
  input  wire                         VCLK_o,
  input  wire                         nVRST_o,
  input  wire                         psel_i,
  input  wire                         penable_i,
  input  wire                         pwrite_i,
  input  wire [7:0]                   paddr_i,
  input  wire [31:0]                  pwdata_i,
  output wire [31:0]                  prdata_o,
  output wire                         pready_o,
  output wire                         pslverr_o,
  input  wire                         vdata_valid_i,
  input  wire [lm_pkg::VDATA_W_I-1:0] vdata_i,
  output wire                         vdata_valid_o,
  output wire [lm_pkg::VDATA_W_O-1:0] vdata_o
);

  localparam int ADDR_W = $clog2(BUF_DEPTH);

  wire                           mult_en, sl_en, sl_id;
  wire [7:0]                     sl_str;
  wire                           wr_en, wr_page, rd_en, rd_page;
  wire [ADDR_W-1:0]              wr_addr, rd_addr;
  wire [3*lm_pkg::COLOR_W_I-1:0] wr_data, rd_data;
  wire                           line_done, done_page, frame_start;
  wire [lm_pkg::LINE_CNT_W-1:0]  line_period;
  wire                           pix_valid, draw_sl, line_active;
  wire [3:0]                     sync_out;

  lm_apb_regs regs_inst (
    .VCLK_o, .nVRST_o, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .mult_en_o(mult_en), .sl_en_o(sl_en), .sl_id_o(sl_id), .sl_str_o(sl_str)
  );

  lm_line_writer #(.BUF_DEPTH(BUF_DEPTH), .H_START(H_START)) writer_inst (
    .VCLK_o, .nVRST_o, .vdata_valid_i, .vdata_i,
    .wr_en_o(wr_en), .wr_page_o(wr_page), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
    .line_done_o(line_done), .done_page_o(done_page), .line_period_o(line_period),
    .frame_start_o(frame_start)
  );

  lm_line_buffer #(.BUF_DEPTH(BUF_DEPTH)) buffer_inst (
    .VCLK_o,
    .wr_en_i(wr_en), .wr_page_i(wr_page), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
    .rd_en_i(rd_en), .rd_page_i(rd_page), .rd_addr_i(rd_addr), .rd_data_o(rd_data)
  );

  lm_line_reader #(.BUF_DEPTH(BUF_DEPTH), .H_START(H_START)) reader_inst (
    .VCLK_o, .nVRST_o, .mult_en_i(mult_en), .sl_en_i(sl_en), .sl_id_i(sl_id),
    .line_done_i(line_done), .done_page_i(done_page), .line_period_i(line_period),
    .frame_start_i(frame_start),
    .rd_en_o(rd_en), .rd_page_o(rd_page), .rd_addr_o(rd_addr),
    .pix_valid_o(pix_valid), .draw_sl_o(draw_sl), .line_active_o(line_active),
    .sync_o(sync_out)
  );

  lm_scanline_out out_inst (
    .VCLK_o, .nVRST_o, .mult_en_i(mult_en), .sl_str_i(sl_str),
    .vdata_valid_i, .vdata_i, .rd_data_i(rd_data),
    .pix_valid_i(pix_valid), .draw_sl_i(draw_sl), .line_active_i(line_active),
    .sync_i(sync_out), .vdata_valid_o, .vdata_o
  );

endmodule

`default_nettype wire

//--- tb_linemult.sv
// testbench for the line doubler with apb setup, video stimulus and assertion checks
`default_nettype none

module tb_linemult;

  localparam int LINE_CYC = 800;  // 200 pixels at one every fourth cycle
  localparam int HALF_CYC = LINE_CYC / 2;
  localparam int X_FIRST  = 2 * 8;
  localparam int X_END    = 2 * (8 + 64);
  localparam int SL_STR   = 96;
  localparam int HS_BIT   = lm_pkg::VDATA_W_O - 4 + lm_pkg::SYNC_HS;
  localparam int VS_BIT   = lm_pkg::VDATA_W_O - 4 + lm_pkg::SYNC_VS;
  localparam int CS_BIT   = lm_pkg::VDATA_W_O - 4 + lm_pkg::SYNC_CS;
  localparam int SP_BIT   = lm_pkg::VDATA_W_O - 4 + 2;  // unused sync slot

  logic        VCLK_o = 1'b0;
  logic        nVRST_o;
  logic        psel, penable, pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        pready, pslverr;
  logic                           vdata_valid_in, vdata_valid_out;
  logic [lm_pkg::VDATA_W_I-1:0]   vdata_in;
  logic [lm_pkg::VDATA_W_O-1:0]   vdata_out;

  integer      seed;
  logic        cfg_started = 1'b0, video_on = 1'b0;
  logic        byp_chk = 1'b0, mult_chk = 1'b0;
  logic        exp_err = 1'b0, rd_chk = 1'b0;
  logic [31:0] exp_rdata = '0;
  logic        exp_sl_en = 1'b0, exp_sl_id = 1'b0;
  int          lcyc = 0, vline = 0, line_no = 0;
  logic [20:0] line_col = '0, last_col = '0;  // current and last completed line colour
  logic [27:0] exp_byp = '0;
  logic        exp_byp_valid = 1'b0;
  logic        hs_q = 1'b1;
  int          hs_gap = 0, hs_low_cnt = 0, vs_line_cnt = 0;
  wire         hs_now = vdata_out[HS_BIT];
  wire         vs_now = vdata_out[VS_BIT];
  wire         cs_now = vdata_out[CS_BIT];

  linemult_top #(.BUF_DEPTH(64), .H_START(8)) linemult_top_inst (
    .VCLK_o, .nVRST_o, .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
    .pslverr_o(pslverr), .vdata_valid_i(vdata_valid_in), .vdata_i(vdata_in),
    .vdata_valid_o(vdata_valid_out), .vdata_o(vdata_out)
  );

  always #20 VCLK_o = ~VCLK_o;

  // top bit of each channel repeated as lsb
  function automatic logic [23:0] widen_color(input logic [20:0] c);
    logic [23:0] r;
    for (int ch = 0; ch < 3; ch++)
      r[ch*8 +: 8] = {c[ch*7 +: 7], c[ch*7+6]};
    return r;
  endfunction

  function automatic logic [23:0] dim_color(input logic [20:0] c);
    logic [23:0] r;
    logic [15:0] p;
    for (int ch = 0; ch < 3; ch++) begin
      p = 16'(c[ch*7 +: 7]) * 16'(255 - SL_STR);
      r[ch*8 +: 8] = 8'(p >> 7);
    end
    return r;
  endfunction

  // output x=0 of repetition 0 is seen six edges after the hsync pixel
  function automatic logic [23:0] expected_color(input int lc, input logic [20:0] col,
                                                 input logic slen, input logic slid);
    int   xo;
    int   x;
    logic rep;
    if (lc < 6)
      return '0;
    xo  = lc - 6;
    rep = (xo >= HALF_CYC);
    x   = rep ? xo - HALF_CYC : xo;
    if (x < X_FIRST || x >= X_END)
      return '0;
    if (slen && (rep == slid))
      return dim_color(col);
    return widen_color(col);
  endfunction

  task automatic fail_check(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic stall_abort(input string msg);
    $display("Timeout: %s", msg);
    $display("Verification failed");
    $fatal(1, "stopping on timeout");
  endtask

  task automatic wait_lines(input int n);
    int target;
    int guard;
    target = line_no + n;
    guard  = 0;
    while (line_no < target) begin
      @(posedge VCLK_o);
      guard++;
      if (guard > n * LINE_CYC + 50)
        stall_abort("input line counter did not advance");
    end
  endtask

  task automatic apb_access(input logic wr, input logic [7:0] addr,
                            input logic [31:0] data, input logic bad);
    int guard;
    @(posedge VCLK_o);
    psel      <= 1'b1;
    penable   <= 1'b0;
    pwrite    <= wr;
    paddr     <= addr;
    pwdata    <= wr ? data : 32'h0;
    exp_err   <= bad;
    exp_rdata <= data;
    rd_chk    <= !wr && !bad;
    @(posedge VCLK_o);
    penable <= 1'b1;
    guard = 0;
    do begin
      @(posedge VCLK_o);
      guard++;
      if (guard > 16)
        stall_abort("apb pready never came");
    end while (!pready);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // video source and output observers
  ////////////////////////////////////////////////////////////

  always @(posedge VCLK_o) begin
    if (video_on) begin
      vdata_valid_in <= (lcyc % 4 == 0);
      vdata_in <= {vline >= 3, 1'b0, (lcyc / 4) >= 8, ((lcyc / 4) >= 8) && (vline >= 3),
                   line_col};
      if (lcyc == LINE_CYC - 1) begin
        lcyc     <= 0;
        last_col <= line_col;
        line_col <= 21'($random(seed));
        vline    <= (vline == 19) ? 0 : vline + 1;  // 20 line frame
        line_no  <= line_no + 1;
      end else begin
        lcyc <= lcyc + 1;
      end
    end
  end

  always @(posedge VCLK_o) begin
    exp_byp       <= {vdata_in[24:21], widen_color(vdata_in[20:0])};
    exp_byp_valid <= vdata_valid_in;
    hs_q          <= hs_now;
    hs_gap        <= (hs_q && !hs_now) ? 1 : hs_gap + 1;
    hs_low_cnt    <= hs_now ? 0 : hs_low_cnt + 1;
    if (vs_now)
      vs_line_cnt <= 0;
    else if (hs_q && !hs_now)
      vs_line_cnt <= vs_line_cnt + 1;
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    !cfg_started |-> (!vdata_valid_out && vdata_out == '0)
  ) else fail_check("output not idle before configuration");

  a_apb_rdata: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    (psel && penable && !pwrite && rd_chk) |-> (prdata == exp_rdata)
  ) else fail_check("apb read data mismatch");

  a_apb_err: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    (psel && penable) |-> (pslverr == exp_err)
  ) else fail_check("apb pslverr mismatch");

  a_bypass: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    byp_chk |-> (vdata_out == exp_byp && vdata_valid_out == exp_byp_valid)
  ) else fail_check("bypass word mismatch");

  a_mult_pixel: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    mult_chk |-> (vdata_valid_out &&
                  vdata_out[23:0] == expected_color(lcyc, last_col, exp_sl_en, exp_sl_id))
  ) else fail_check("doubled pixel colour mismatch");

  // csync follows hsync and flips while vsync is low
  a_csync: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    mult_chk |-> (cs_now == (vs_now ? hs_now : !hs_now) && vdata_out[SP_BIT] == 1'b0)
  ) else fail_check("output csync or spare sync bit wrong");

  a_hs_width: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    (mult_chk && $rose(hs_now)) |-> (hs_low_cnt == lm_pkg::HS_WIDTH_2X)
  ) else fail_check("output hsync pulse width wrong");

  a_hs_period: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    (mult_chk && $fell(hs_now)) |-> (hs_gap == HALF_CYC)
  ) else fail_check("output line period wrong");

  a_vs_lines: assert property (@(posedge VCLK_o) disable iff (!nVRST_o)
    (mult_chk && $rose(vs_now)) |-> (vs_line_cnt == lm_pkg::VS_LINES)
  ) else fail_check("output vsync line count wrong");

  initial begin
    seed           = 79687;
    nVRST_o        = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = 8'h0;
    pwdata         = 32'h0;
    vdata_valid_in = 1'b0;
    vdata_in       = '0;
    repeat (16) @(posedge VCLK_o);
    nVRST_o <= 1'b1;
    repeat (8) @(posedge VCLK_o);

    cfg_started <= 1'b1;
    apb_access(1'b1, lm_pkg::ADDR_CTRL, 32'h6, 1'b0);
    apb_access(1'b0, lm_pkg::ADDR_CTRL, 32'h6, 1'b0);
    apb_access(1'b1, lm_pkg::ADDR_SL_STR, SL_STR, 1'b0);
    apb_access(1'b0, lm_pkg::ADDR_SL_STR, SL_STR, 1'b0);
    apb_access(1'b1, 8'h08, 32'hA5, 1'b1);
    apb_access(1'b0, 8'h08, 32'h0, 1'b1);
    apb_access(1'b1, lm_pkg::ADDR_CTRL, 32'h0, 1'b0);

    // pass through
    video_on <= 1'b1;
    wait_lines(1);
    byp_chk <= 1'b1;
    wait_lines(2);
    byp_chk <= 1'b0;

    // doubled without scanline over a full frame
    apb_access(1'b1, lm_pkg::ADDR_CTRL, 32'h1, 1'b0);
    wait_lines(2);
    mult_chk <= 1'b1;
    wait_lines(21);
    mult_chk <= 1'b0;

    exp_sl_en <= 1'b1;
    exp_sl_id <= 1'b0;
    apb_access(1'b1, lm_pkg::ADDR_CTRL, 32'h3, 1'b0);
    wait_lines(2);
    mult_chk <= 1'b1;
    wait_lines(4);
    mult_chk <= 1'b0;

    exp_sl_id <= 1'b1;
    apb_access(1'b1, lm_pkg::ADDR_CTRL, 32'h7, 1'b0);
    wait_lines(2);
    mult_chk <= 1'b1;
    wait_lines(4);
    mult_chk <= 1'b0;

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
lm_pkg.sv
lm_apb_regs.sv
lm_line_writer.sv
lm_line_buffer.sv
lm_line_reader.sv
lm_scanline_out.sv
linemult_top.sv
tb_linemult.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_linemult

run: build
	out=$$(./obj_dir/Vtb_linemult); echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

lint:
	verilator --lint-only -Wall -f sources.f --top-module linemult_top

clean:
	rm -rf obj_dir
